// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_turf_ctrl
FLIST      := turf_ctrl.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed
COMMON     := --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f $(FLIST)
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 --Mdir $(BUILD_DIR) $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== turf_ctrl.f ====
+incdir+verilog
verilog/turf_ctrl_pkg.sv
verilog/uart_tick_gen.sv
verilog/turf_id_regs.sv
verilog/link_up_monitor.sv
verilog/crate_bridge_select.sv
verilog/turf_ctrl_top.sv
verif/tb_turf_ctrl.sv

// ==== verif/tb_turf_ctrl.sv ====
`timescale 1ns/10ps
`include "turf_ctrl_macros.svh"

module tb_turf_ctrl import turf_ctrl_pkg::*; ();

    localparam int    CLK_PERIOD   = 8;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DLY    = 1;
    localparam int    RSP_WAIT     = 4;
    localparam int    LINK_SETTLE  = 4;
    localparam string TRACE_FILE   = "verif/turf_ctrl_trace.txt";

    logic       ps_clk;
    logic       arst_n_i;
    reg_req_t   reg_req;
    reg_rsp_t   reg_rsp;
    link_mask_t link_up;
    crate_req_t crate_req;
    crate_rsp_t crate_rsp;
    logic       hsk_tick;
    logic       gps_tick;

    string      trace_q[$];
    logic       trace_loaded = 1'b0;
    logic       counting = 1'b0;
    int         cycles = 0;
    int         hsk_count = 0;
    int         gps_count = 0;
    int         num_tests = 0;
    int         num_errors = 0;

    turf_ctrl_top u_dut (
        .ps_clk      (ps_clk),
        .arst_n_i    (arst_n_i),
        .reg_req_i   (reg_req),
        .reg_rsp_o   (reg_rsp),
        .link_up_i   (link_up),
        .crate_req_i (crate_req),
        .crate_rsp_o (crate_rsp),
        .hsk_tick_o  (hsk_tick),
        .gps_tick_o  (gps_tick)
    );

    initial begin
        ps_clk = 1'b0;
        forever #(CLK_PERIOD / 2) ps_clk = ~ps_clk;
    end

    // Strobe counts from reset release to end of trace
    always @(posedge ps_clk) begin
        if (counting) begin
            cycles    <= cycles + 1;
            hsk_count <= hsk_count + int'(hsk_tick);
            gps_count <= gps_count + int'(gps_tick);
        end
    end

    // Budget scales with trace length
    initial begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = trace_q.size() * 20 + 200;
        repeat (limit) @(posedge ps_clk);
        $display("Timeout: trace did not finish within %0d cycles", limit);
        $display("Verification failed");
        $finish;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_reg_rsp(input string name, input reg_rsp_t got, input reg_rsp_t exp);
        num_tests++;
        if (got !== exp) begin
            num_errors++;
            $display("** Error: %s reg_rsp_o.rdata = 0x%08h, expected 0x%08h",
                     name, got.rdata, exp.rdata);
        end else begin
            $display("ok   %s reg_rsp_o.rdata = 0x%08h", name, got.rdata);
        end
    endtask

    task automatic check_crate_rsp(input string name, input crate_rsp_t got,
                                   input crate_rsp_t exp);
        num_tests++;
        if (got !== exp) begin
            num_errors++;
            $display("** Error: %s crate_rsp_o = 0x%02h, expected 0x%02h", name, got, exp);
        end else begin
            $display("ok   %s crate_rsp_o = 0x%02h", name, got);
        end
    endtask

    task automatic check_tick_count(input string name, input longint got, input longint exp);
        longint diff;
        num_tests++;
        diff = got - exp;
        if (diff > 1 || diff < -1) begin
            num_errors++;
            $display("** Error: %s count = 0x%0h, expected 0x%0h within one", name, got, exp);
        end else begin
            $display("ok   %s count = %0d, expected %0d", name, got, exp);
        end
    endtask

    //////////////////////////////
    // Bus drivers
    //////////////////////////////

    task automatic reg_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp_rdata, input string name);
        reg_rsp_t exp;
        int       waited;
        @(posedge ps_clk);
        #DRIVE_DLY;
        reg_req.valid = 1'b1;
        reg_req.write = wr;
        reg_req.addr  = addr;
        reg_req.wdata = wdata;
        @(posedge ps_clk);
        #DRIVE_DLY;
        reg_req = '0;
        waited  = 0;
        while (!reg_rsp.valid && waited < RSP_WAIT) begin
            @(posedge ps_clk);
            #DRIVE_DLY;
            waited++;
        end
        if (!reg_rsp.valid) begin
            num_tests++;
            num_errors++;
            $display("%s got no register response within %0d cycles", name, RSP_WAIT);
        end else if (waited != 0) begin
            num_tests++;
            num_errors++;
            $display("%s got its register response %0d cycles late", name, waited);
        end else begin
            exp.valid = 1'b1;
            exp.rdata = exp_rdata;
            check_reg_rsp(name, reg_rsp, exp);
        end
    endtask

    task automatic crate_access(input logic [1:0] link, input crate_rsp_t exp, input string name);
        int waited;
        @(posedge ps_clk);
        #DRIVE_DLY;
        crate_req.valid = 1'b1;
        crate_req.link  = link;
        @(posedge ps_clk);
        #DRIVE_DLY;
        crate_req = '0;
        waited    = 0;
        while (!(crate_rsp.valid || crate_rsp.invalid) && waited < RSP_WAIT) begin
            @(posedge ps_clk);
            #DRIVE_DLY;
            waited++;
        end
        if (!(crate_rsp.valid || crate_rsp.invalid)) begin
            num_tests++;
            num_errors++;
            $display("%s got no crate response within %0d cycles", name, RSP_WAIT);
        end else if (waited != 0) begin
            num_tests++;
            num_errors++;
            $display("%s got its crate response %0d cycles late", name, waited);
        end else begin
            check_crate_rsp(name, crate_rsp, exp);
        end
    endtask

    //////////////////////////////
    // Trace handling
    //////////////////////////////

    task automatic load_trace(output bit ok);
        int    fd;
        string line;
        byte   first;
        fd = $fopen(TRACE_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) != 0) begin
                // Comment and blank lines carry no operation
                if ($sscanf(line, " %c", first) == 1 && first != "#") begin
                    trace_q.push_back(line);
                end
            end
            $fclose(fd);
        end else begin
            $display("Could not open trace file %s", TRACE_FILE);
        end
    endtask

    task automatic bad_line(input int idx, input string line);
        num_errors++;
        $display("Trace operation %0d is malformed: %s", idx, line);
    endtask

    task automatic run_op(input int idx, input string line);
        byte         op;
        byte         res;
        logic [31:0] addr;
        logic [31:0] data;
        int          link;
        int          typ;
        int          fields;
        crate_rsp_t  exp;
        fields = $sscanf(line, " %c", op);
        case (op)
            "W": begin
                if ($sscanf(line, " %c %h %h", op, addr, data) == 3) begin
                    reg_access(1'b1, addr[3:0], data, 32'h0,
                               $sformatf("op %0d write 0x%0h", idx, addr[3:0]));
                end else begin
                    bad_line(idx, line);
                end
            end
            "R": begin
                if ($sscanf(line, " %c %h %h", op, addr, data) == 3) begin
                    reg_access(1'b0, addr[3:0], 32'h0, data,
                               $sformatf("op %0d read 0x%0h", idx, addr[3:0]));
                end else begin
                    bad_line(idx, line);
                end
            end
            "U": begin
                if ($sscanf(line, " %c %h", op, data) == 2) begin
                    @(posedge ps_clk);
                    #DRIVE_DLY;
                    link_up = data[3:0];
                    repeat (LINK_SETTLE) @(posedge ps_clk);
                end else begin
                    bad_line(idx, line);
                end
            end
            "C": begin
                fields = $sscanf(line, " %c %d %c %d", op, link, res, typ);
                if (fields == 4 && (res == "V" || res == "I")) begin
                    exp.valid   = (res == "V");
                    exp.invalid = (res == "I");
                    exp.link    = link[1:0];
                    exp.btype   = bridge_type_e'(typ[1:0]);
                    crate_access(link[1:0], exp, $sformatf("op %0d crate link %0d", idx, link));
                end else begin
                    bad_line(idx, line);
                end
            end
            "N": begin
                if ($sscanf(line, " %c %d", op, typ) == 2) begin
                    repeat (typ) @(posedge ps_clk);
                end else begin
                    bad_line(idx, line);
                end
            end
            default: bad_line(idx, line);
        endcase
    endtask

    // Strobe count is floor(k * ADD / 2^W)
    task automatic check_ticks();
        longint exp_hsk;
        longint exp_gps;
        exp_hsk = (longint'(cycles) * `HSK_TICK_ADD) / (longint'(1) << `HSK_TICK_W);
        exp_gps = (longint'(cycles) * `GPS_TICK_ADD) / (longint'(1) << `GPS_TICK_W);
        check_tick_count("hsk_tick_o", longint'(hsk_count), exp_hsk);
        check_tick_count("gps_tick_o", longint'(gps_count), exp_gps);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin : main
        bit ok;
        arst_n_i  = 1'b0;
        reg_req   = '0;
        crate_req = '0;
        link_up   = '0;
        load_trace(ok);
        trace_loaded = 1'b1;
        if (ok) begin
            repeat (RESET_CYCLES) @(posedge ps_clk);
            #DRIVE_DLY;
            arst_n_i = 1'b1;
            counting = 1'b1;
            foreach (trace_q[i]) begin
                run_op(i, trace_q[i]);
            end
            @(posedge ps_clk);
            #DRIVE_DLY;
            counting = 1'b0;
            check_ticks();
        end else begin
            num_errors++;
        end
        $display("Tests run: %0d, errors: %0d", num_tests, num_errors);
        if (num_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== verif/turf_ctrl_trace.txt ====
# W addr data | R addr expected rdata | U link_up mask (all hex)
# C link result(V/I) btype (decimal) | N idle cycles (decimal)
# Reset values
R 0 54555246
R 1 BA5C040A
R 2 00000000
R 4 00000000
R 3 00000000
# Scratch, bridge and unmapped addresses
W 4 DEADBEEF
R 4 DEADBEEF
W 2 FFFFFF1B
R 2 0000001B
W 2 00000000
R 2 00000000
R 7 00000000
W 9 12345678
R 9 00000000
# All links NONE, valid whether up or down
C 0 V 0
C 1 V 0
C 2 V 0
C 3 V 0
U F
C 2 V 0
R 3 0000000F
# Link 0 and 3 AURORA, link 1 SPARE2, link 2 SPARE3
W 2 00000079
C 0 V 1
C 3 V 1
C 1 I 2
C 2 I 3
R 3 0000060F
U 7
C 3 I 1
C 0 V 1
R 3 00000E87
# Write-one-to-clear on status
W 3 00000080
R 3 00000E07
W 3 00000200
R 3 00000C07
U 0
R 3 00000C70
W 3 00000FF0
R 3 00000000
C 0 I 1
R 3 00000100
N 10
W 2 00000000
C 1 V 0
N 10
R 3 00000100

// ==== verilog/crate_bridge_select.sv ====
`timescale 1ns/10ps
`include "turf_ctrl_macros.svh"

module crate_bridge_select import turf_ctrl_pkg::*; (
    input  logic                      ps_clk,
    input  logic                      arst_n_i,
    input  crate_req_t                crate_req_i,
    input  logic [`TURF_BRIDGE_W-1:0] bridge_types_i,
    input  link_mask_t                link_up_i,
    input  sticky_clr_t               sticky_clr_i,
    output crate_rsp_t                crate_rsp_o,
    output link_mask_t                link_invalid_o
);

    bridge_type_e req_type;
    logic         type_ok;
    link_mask_t   inv_set;
    link_mask_t   clr_mask;
    link_mask_t   invalid_q;
    logic         rsp_valid_q;
    logic         rsp_invalid_q;
    logic [`TURF_LINK_IDX_W-1:0] rsp_link_q;
    bridge_type_e rsp_type_q;

    //////////////////////////////
    // Validity table
    //////////////////////////////

    assign req_type = bridge_type_e'(bridge_types_i[{crate_req_i.link, 1'b0} +: 2]);

    // NONE always passes, AURORA needs the link up, spares never pass
    always_comb begin
        case (req_type)
            BRIDGE_NONE:   type_ok = 1'b1;
            BRIDGE_AURORA: type_ok = link_up_i[crate_req_i.link];
            default:       type_ok = 1'b0;
        endcase
    end

    always_comb begin
        inv_set = '0;
        inv_set[crate_req_i.link] = crate_req_i.valid & ~type_ok;
    end

    assign clr_mask = sticky_clr_i.valid ? sticky_clr_i.invalid_mask : '0;

    //////////////////////////////
    // Response and sticky flags
    //////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_q   <= 1'b0;
            rsp_invalid_q <= 1'b0;
            invalid_q     <= '0;
        end else begin
            rsp_valid_q   <= crate_req_i.valid & type_ok;
            rsp_invalid_q <= crate_req_i.valid & ~type_ok;
            invalid_q     <= (invalid_q & ~clr_mask) | inv_set;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (crate_req_i.valid) begin
            rsp_link_q <= crate_req_i.link;
            rsp_type_q <= req_type;
        end
    end

    assign crate_rsp_o.valid   = rsp_valid_q;
    assign crate_rsp_o.invalid = rsp_invalid_q;
    assign crate_rsp_o.link    = rsp_link_q;
    assign crate_rsp_o.btype   = rsp_type_q;
    assign link_invalid_o      = invalid_q;

    a_valid_invalid_excl: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i)
        !(crate_rsp_o.valid && crate_rsp_o.invalid)
    );

endmodule

// ==== verilog/link_up_monitor.sv ====
`timescale 1ns/10ps

module link_up_monitor import turf_ctrl_pkg::*; (
    input  logic        ps_clk,
    input  logic        arst_n_i,
    input  link_mask_t  link_up_i,
    input  sticky_clr_t sticky_clr_i,
    output link_mask_t  link_up_o,
    output link_mask_t  link_drop_o
);

    link_mask_t sync1_q;
    link_mask_t sync2_q;
    link_mask_t prev_q;
    link_mask_t drop_q;
    link_mask_t fall;
    link_mask_t clr_mask;

    // Link-up comes from the Aurora user clock domain
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= link_up_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    // Falling edge of the synchronized bit
    assign fall     = prev_q & ~sync2_q;
    assign clr_mask = sticky_clr_i.valid ? sticky_clr_i.drop_mask : '0;

    // Sticky drop flags, a new drop beats a clear
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            drop_q <= '0;
        end else begin
            drop_q <= (drop_q & ~clr_mask) | fall;
        end
    end

    assign link_up_o   = sync2_q;
    assign link_drop_o = drop_q;

endmodule

// ==== verilog/turf_ctrl_macros.svh ====
`ifndef TURF_CTRL_MACROS_SVH
`define TURF_CTRL_MACROS_SVH

// Identification, ASCII "TURF"
`define TURF_IDENT          32'h54555246

// Firmware version fields
`define TURF_VER_MAJOR      4'd0
`define TURF_VER_MINOR      4'd4
`define TURF_VER_REV        8'd10
// Only the low 15 bits land in the date/version word
`define TURF_FW_DATE        16'h3A5C
`define TURF_REV_B          1'b1

// Widths
`define TURF_NUM_LINKS      4
`define TURF_LINK_IDX_W     2
`define TURF_BRIDGE_W       8
`define TURF_REG_ADDR_W     4
`define TURF_REG_DATA_W     32

// Register word addresses
`define TURF_ADDR_IDENT     4'h0
`define TURF_ADDR_DATEVER   4'h1
`define TURF_ADDR_BRIDGE    4'h2
`define TURF_ADDR_STATUS    4'h3
`define TURF_ADDR_SCRATCH   4'h4

// UART debug baud strobes
`define HSK_TICK_ADD        82
`define HSK_TICK_W          10
`define GPS_TICK_ADD        25
`define GPS_TICK_W          12

`endif

// ==== verilog/turf_ctrl_pkg.sv ====
`include "turf_ctrl_macros.svh"

package turf_ctrl_pkg;

    // Per-link bridge selection, two bits each
    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_SPARE2 = 2'd2,
        BRIDGE_SPARE3 = 2'd3
    } bridge_type_e;

    // One bit per TURFIO link
    typedef logic [`TURF_NUM_LINKS-1:0] link_mask_t;

    //////////////////////////////
    // Register port
    //////////////////////////////

    // Single-cycle strobe, no back-pressure
    typedef struct packed {
        logic                        valid;
        logic                        write;
        logic [`TURF_REG_ADDR_W-1:0] addr;
        logic [`TURF_REG_DATA_W-1:0] wdata;
    } reg_req_t;

    // Returned one cycle after the request
    typedef struct packed {
        logic                        valid;
        logic [`TURF_REG_DATA_W-1:0] rdata;
    } reg_rsp_t;

    //////////////////////////////
    // Crate access port
    //////////////////////////////

    typedef struct packed {
        logic                        valid;
        logic [`TURF_LINK_IDX_W-1:0] link;
    } crate_req_t;

    // Exactly one of valid or invalid per access
    typedef struct packed {
        logic                        valid;
        logic                        invalid;
        logic [`TURF_LINK_IDX_W-1:0] link;
        bridge_type_e                btype;
    } crate_rsp_t;

    // Write-one-to-clear strobe for the sticky status bits
    typedef struct packed {
        logic       valid;
        link_mask_t drop_mask;
        link_mask_t invalid_mask;
    } sticky_clr_t;

endpackage

// ==== verilog/turf_ctrl_top.sv ====
`timescale 1ns/10ps
`include "turf_ctrl_macros.svh"

module turf_ctrl_top import turf_ctrl_pkg::*; (
    input  logic       ps_clk,
    input  logic       arst_n_i,
    input  reg_req_t   reg_req_i,
    output reg_rsp_t   reg_rsp_o,
    input  link_mask_t link_up_i,
    input  crate_req_t crate_req_i,
    output crate_rsp_t crate_rsp_o,
    output logic       hsk_tick_o,
    output logic       gps_tick_o
);

    logic [`TURF_BRIDGE_W-1:0] bridge_types;
    sticky_clr_t               sticky_clr;
    link_mask_t                link_up;
    link_mask_t                link_drop;
    link_mask_t                link_invalid;

    //////////////////////////////
    // ID and control registers
    //////////////////////////////

    turf_id_regs u_id_regs (
        .ps_clk         (ps_clk),
        .arst_n_i       (arst_n_i),
        .reg_req_i      (reg_req_i),
        .reg_rsp_o      (reg_rsp_o),
        .link_up_i      (link_up),
        .link_drop_i    (link_drop),
        .link_invalid_i (link_invalid),
        .bridge_types_o (bridge_types),
        .sticky_clr_o   (sticky_clr)
    );

    link_up_monitor u_link_mon (
        .ps_clk       (ps_clk),
        .arst_n_i     (arst_n_i),
        .link_up_i    (link_up_i),
        .sticky_clr_i (sticky_clr),
        .link_up_o    (link_up),
        .link_drop_o  (link_drop)
    );

    // Crate bridge validity
    crate_bridge_select u_bridge_sel (
        .ps_clk         (ps_clk),
        .arst_n_i       (arst_n_i),
        .crate_req_i    (crate_req_i),
        .bridge_types_i (bridge_types),
        .link_up_i      (link_up),
        .sticky_clr_i   (sticky_clr),
        .crate_rsp_o    (crate_rsp_o),
        .link_invalid_o (link_invalid)
    );

    //////////////////////////////
    // UART debug strobes
    //////////////////////////////

    // 16x housekeeping rate, 82/1024 of ps_clk
    uart_tick_gen #(.ADD(`HSK_TICK_ADD), .ACC_W(`HSK_TICK_W)) u_hsk_tick (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .tick_o   (hsk_tick_o)
    );

    // 16x GPS rate, 25/4096 of ps_clk
    uart_tick_gen #(.ADD(`GPS_TICK_ADD), .ACC_W(`GPS_TICK_W)) u_gps_tick (
        .ps_clk   (ps_clk),
        .arst_n_i (arst_n_i),
        .tick_o   (gps_tick_o)
    );

endmodule

// ==== verilog/turf_id_regs.sv ====
`timescale 1ns/10ps
`include "turf_ctrl_macros.svh"

module turf_id_regs import turf_ctrl_pkg::*; (
    input  logic                      ps_clk,
    input  logic                      arst_n_i,
    input  reg_req_t                  reg_req_i,
    output reg_rsp_t                  reg_rsp_o,
    input  link_mask_t                link_up_i,
    input  link_mask_t                link_drop_i,
    input  link_mask_t                link_invalid_i,
    output logic [`TURF_BRIDGE_W-1:0] bridge_types_o,
    output sticky_clr_t               sticky_clr_o
);

    localparam int N = `TURF_NUM_LINKS;
    localparam int STATUS_PAD = `TURF_REG_DATA_W - 3 * N;
    localparam int BRIDGE_PAD = `TURF_REG_DATA_W - `TURF_BRIDGE_W;

    localparam logic [15:0] FW_DATE = `TURF_FW_DATE;
    // Rev flag, 15-bit date, then major/minor/rev
    localparam logic [`TURF_REG_DATA_W-1:0] DATEVERSION = {
        `TURF_REV_B, FW_DATE[14:0], `TURF_VER_MAJOR, `TURF_VER_MINOR, `TURF_VER_REV
    };

    logic [`TURF_BRIDGE_W-1:0]   bridge_q;
    logic [`TURF_REG_DATA_W-1:0] scratch_q;
    logic [`TURF_REG_DATA_W-1:0] rd_data;
    logic [`TURF_REG_DATA_W-1:0] rdata_q;
    logic                        rsp_valid_q;
    sticky_clr_t                 clr_q;

    //////////////////////////////
    // Read mux
    //////////////////////////////

    always_comb begin
        case (reg_req_i.addr)
            `TURF_ADDR_IDENT:   rd_data = `TURF_IDENT;
            `TURF_ADDR_DATEVER: rd_data = DATEVERSION;
            `TURF_ADDR_BRIDGE:  rd_data = {{BRIDGE_PAD{1'b0}}, bridge_q};
            `TURF_ADDR_STATUS:  rd_data = {{STATUS_PAD{1'b0}}, link_invalid_i,
                                           link_drop_i, link_up_i};
            `TURF_ADDR_SCRATCH: rd_data = scratch_q;
            default:            rd_data = '0;
        endcase
    end

    //////////////////////////////
    // Writes and response
    //////////////////////////////

    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bridge_q    <= '0;
            scratch_q   <= '0;
            rsp_valid_q <= 1'b0;
            clr_q       <= '0;
        end else begin
            rsp_valid_q  <= reg_req_i.valid;
            clr_q.valid  <= 1'b0;
            if (reg_req_i.valid && reg_req_i.write) begin
                case (reg_req_i.addr)
                    `TURF_ADDR_BRIDGE:  bridge_q  <= reg_req_i.wdata[`TURF_BRIDGE_W-1:0];
                    `TURF_ADDR_SCRATCH: scratch_q <= reg_req_i.wdata;
                    `TURF_ADDR_STATUS: begin
                        clr_q.valid        <= 1'b1;
                        clr_q.drop_mask    <= reg_req_i.wdata[2*N-1:N];
                        clr_q.invalid_mask <= reg_req_i.wdata[3*N-1:2*N];
                    end
                    default: ;
                endcase
            end
        end
    end

    // Writes answer with zero
    always_ff @(posedge ps_clk) begin
        if (reg_req_i.valid) begin
            rdata_q <= reg_req_i.write ? '0 : rd_data;
        end
    end

    assign reg_rsp_o.valid = rsp_valid_q;
    assign reg_rsp_o.rdata = rdata_q;
    assign bridge_types_o  = bridge_q;
    assign sticky_clr_o    = clr_q;

    // Every request is answered in the next cycle
    a_rsp_follows_req: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) reg_req_i.valid |=> reg_rsp_o.valid
    );

    // No response without a request the cycle before
    a_no_spurious_rsp: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) reg_rsp_o.valid |-> $past(reg_req_i.valid)
    );

endmodule

// ==== verilog/uart_tick_gen.sv ====
`timescale 1ns/10ps

module uart_tick_gen import turf_ctrl_pkg::*; #(
    parameter int ADD   = 82,
    parameter int ACC_W = 10
) (
    input  logic ps_clk,
    input  logic arst_n_i,
    output logic tick_o
);

    // One extra bit so the carry falls out of the sum
    localparam logic [ACC_W:0] ADD_EXT = (ACC_W + 1)'(ADD);

    logic [ACC_W-1:0] acc_q;
    logic             tick_q;

    // Carry of the modulo-2^ACC_W sum is the strobe
    always_ff @(posedge ps_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            {tick_q, acc_q} <= {1'b0, acc_q} + ADD_EXT;
        end
    end

    assign tick_o = tick_q;

    // Increment must stay below the modulus or strobes get lost
    a_add_below_modulus: assert property (
        @(posedge ps_clk) disable iff (!arst_n_i) ADD < (2 ** ACC_W)
    );

endmodule
